/* vlog.f */
design/sm83_regs_pkg.sv
design/regs_wb_port.sv
design/regs_cmd_decode.sv
design/reg_pair.sv
design/regs_read_mux.sv
design/sm83_regs_top.sv
testbench/tb_sm83_regs.sv

/* Bender.yml */
package:
  name: sm83_regs

sources:
  - files:
      - design/sm83_regs_pkg.sv
      - design/regs_wb_port.sv
      - design/regs_cmd_decode.sv
      - design/reg_pair.sv
      - design/regs_read_mux.sv
      - design/sm83_regs_top.sv
  - target: test
    files:
      - testbench/tb_sm83_regs.sv

/* testbench/tb_sm83_regs.sv */
// SM83 register block testbench

`timescale 1ns/1ps

module tb_sm83_regs;

	localparam int pairs = 6;
	localparam int ack_limit = 20;	// Cycles allowed per transfer

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	logic [15:0] model [pairs];	// BC DE HL SP PC WZ
	int          pass_count;
	int          fail_count;
	int          test_fails;	// Fail count when the current test began
	int          test_num;

	sm83_regs_top #(.num_pairs(pairs)) uut (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #4 clk = ~clk;

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) begin
			pass_count++;
		end else begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			fail_count++;
		end
	endtask

	// One Wishbone classic transfer, starting and ending 1 ns after an edge
	task automatic bus_transfer(input logic we, input logic [2:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int  cycles;
		bit  got_ack;
		cycles  = 0;
		got_ack = 0;
		rdata   = '0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		while (!got_ack && cycles < ack_limit) begin
			@(posedge clk);
			#1;
			cycles++;
			got_ack = wb_ack;
		end
		rdata  = wb_dat_r;	// Registered on the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (!got_ack) begin
			$display("timeout: no wb_ack within %0d cycles at address %0d", ack_limit, adr);
			fail_count++;
		end else begin
			@(posedge clk);
			#1;
			check_equal("wb_ack after stb drop", {31'b0, wb_ack}, 32'h0);
		end
	endtask

	function automatic logic [7:0] model_byte(input int idx);
		return idx[0] ? model[idx / 2][7:0] : model[idx / 2][15:8];
	endfunction

	task automatic set_model_byte(input int idx, input logic [7:0] val);
		if (idx[0]) begin
			model[idx / 2][7:0] = val;
		end else begin
			model[idx / 2][15:8] = val;
		end
	endtask

	task automatic send_byte_imm(input int dst, input logic [7:0] imm);
		logic [31:0] word;
		logic [31:0] unused;
		word = {1'b0, dst[3:0], 4'h0, 1'b1, 14'h0, imm};	// Byte view, immediate
		bus_transfer(1'b1, 3'd7, word, unused);
		set_model_byte(dst, imm);
	endtask

	task automatic send_byte_copy(input int dst, input int src);
		logic [31:0] word;
		logic [31:0] unused;
		word = {1'b0, dst[3:0], src[3:0], 1'b0, 14'h0, 8'h00};
		bus_transfer(1'b1, 3'd7, word, unused);
		set_model_byte(dst, model_byte(src));
	endtask

	task automatic send_pair_op(input int idx, input logic [1:0] op, input logic [15:0] imm);
		logic [31:0] word;
		logic [31:0] unused;
		word = {1'b1, op, idx[2:0], 10'h0, imm};	// Pair view
		bus_transfer(1'b1, 3'd7, word, unused);
		case (op)
			sm83_regs_pkg::pop_inc:  model[idx] = model[idx] + 16'd1;
			sm83_regs_pkg::pop_dec:  model[idx] = model[idx] - 16'd1;
			sm83_regs_pkg::pop_load: model[idx] = imm;
			default:                 model[idx] = model[idx] + {{8{imm[7]}}, imm[7:0]};
		endcase
	endtask

	task automatic compare_all_pairs();
		logic [31:0] rd;
		for (int i = 0; i < pairs; i++) begin
			bus_transfer(1'b0, i[2:0], 32'h0, rd);
			check_equal($sformatf("pair%0d", i), rd, {16'h0, model[i]});
		end
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (fail_count == test_fails) begin
			$display("[%0d] %s: ok", test_num, name);
		end else begin
			$display("[%0d] %s: %0d errors", test_num, name, fail_count - test_fails);
		end
		test_fails = fail_count;
	endtask

	initial begin
		logic [31:0] rd;
		logic [15:0] base;
		int          dst;
		void'($urandom(32'hb0425ed7));
		clk        = 1'b0;
		arst_n     = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		pass_count = 0;
		fail_count = 0;
		test_fails = 0;
		test_num   = 0;
		for (int i = 0; i < pairs; i++) begin
			model[i] = 16'h0;
		end
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Reset state
		check_equal("wb_dat_r", wb_dat_r, 32'h0);
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			#1;
			check_equal("wb_ack while idle", {31'b0, wb_ack}, 32'h0);
		end
		compare_all_pairs();
		finish_test("reset");

		// Byte loads then byte copies
		for (int i = 0; i < 24; i++) begin
			send_byte_imm($urandom % 12, 8'($urandom));
		end
		for (int i = 0; i < 24; i++) begin
			send_byte_copy($urandom % 12, $urandom % 12);
		end
		compare_all_pairs();
		finish_test("byte commands");

		// Wrap at both ends
		for (int i = 0; i < pairs; i++) begin
			send_pair_op(i, sm83_regs_pkg::pop_load, 16'hffff);
			send_pair_op(i, sm83_regs_pkg::pop_inc, 16'h0);
			bus_transfer(1'b0, i[2:0], 32'h0, rd);
			check_equal($sformatf("pair%0d inc wrap", i), rd, 32'h0);
			send_pair_op(i, sm83_regs_pkg::pop_dec, 16'h0);
			send_pair_op(i, sm83_regs_pkg::pop_dec, 16'h0);
		end
		compare_all_pairs();
		finish_test("increment and decrement");

		// Negative offset across a page boundary first
		send_pair_op(2, sm83_regs_pkg::pop_load, 16'h1205);
		send_pair_op(2, sm83_regs_pkg::pop_add_off, 16'h00f0);
		bus_transfer(1'b0, 3'd2, 32'h0, rd);
		check_equal("pair2 page cross", rd, 32'h000011f5);
		for (int i = 0; i < 40; i++) begin
			base = 16'($urandom);
			send_pair_op(i % pairs, sm83_regs_pkg::pop_load, base);
			send_pair_op(i % pairs, sm83_regs_pkg::pop_add_off, 16'($urandom));
		end
		compare_all_pairs();
		finish_test("immediate load and offset add");

		// Protocol corner cases
		wb_cyc = 1'b1;	// Cycle open but no strobe
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			check_equal("wb_ack without stb", {31'b0, wb_ack}, 32'h0);
		end
		wb_cyc = 1'b0;
		bus_transfer(1'b0, 3'd6, 32'h0, rd);
		check_equal("read adr 6", rd, 32'h0);
		bus_transfer(1'b0, 3'd7, 32'h0, rd);
		check_equal("read adr 7", rd, 32'h0);
		bus_transfer(1'b1, 3'd3, $urandom, rd);	// Not the command address
		bus_transfer(1'b1, 3'd0, 32'h8000_ffff, rd);
		compare_all_pairs();
		finish_test("protocol");

		// Random mix of valid commands
		for (int n = 1; n <= 300; n++) begin
			dst = $urandom % 12;
			case ($urandom % 3)
				0:       send_byte_imm(dst, 8'($urandom));
				1:       send_byte_copy(dst, $urandom % 12);
				default: send_pair_op($urandom % pairs, 2'($urandom), 16'($urandom));
			endcase
			if (n % 20 == 0) begin
				compare_all_pairs();
			end
		end
		finish_test("random mix");

		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule // tb_sm83_regs

/* design/sm83_regs_top.sv */
// SM83 register pair block

`timescale 1ns/1ps

module sm83_regs_top #(
	parameter int num_pairs = 6
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic [sm83_regs_pkg::wb_aw-1:0] wb_adr,
	input  logic [sm83_regs_pkg::wb_dw-1:0] wb_dat_w,
	output logic [sm83_regs_pkg::wb_dw-1:0] wb_dat_r,
	output logic                            wb_ack
);

	logic                            cmd_valid;
	sm83_regs_pkg::reg_cmd_u         cmd;
	logic [sm83_regs_pkg::wb_aw-1:0] rd_sel;
	logic [15:0]                     rd_data;
	logic [3:0]                      src_sel;
	logic [7:0]                      src_byte;
	logic [num_pairs-1:0]            we_hi;
	logic [num_pairs-1:0]            we_lo;
	logic [num_pairs-1:0]            op_en;
	logic [7:0]                      byte_data;
	logic [1:0]                      pair_op;
	logic [15:0]                     pair_imm;
	logic [15:0]                     pair_val [num_pairs];	// BC DE HL SP PC WZ

	regs_wb_port u_port (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.rd_data   (rd_data),
		.wb_ack    (wb_ack),
		.wb_dat_r  (wb_dat_r),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.rd_sel    (rd_sel)
	);

	regs_cmd_decode #(.num_pairs(num_pairs)) u_decode (
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.src_byte  (src_byte),
		.src_sel   (src_sel),
		.we_hi     (we_hi),
		.we_lo     (we_lo),
		.byte_data (byte_data),
		.op_en     (op_en),
		.pair_op   (pair_op),
		.pair_imm  (pair_imm)
	);

	for (genvar i = 0; i < num_pairs; i++) begin : g_pair
		reg_pair u_pair (
			.clk       (clk),
			.arst_n    (arst_n),
			.we_hi     (we_hi[i]),
			.we_lo     (we_lo[i]),
			.byte_data (byte_data),
			.op_en     (op_en[i]),
			.pair_op   (pair_op),
			.pair_imm  (pair_imm),
			.value     (pair_val[i])
		);
	end

	regs_read_mux #(.num_pairs(num_pairs)) u_mux (
		.values   (pair_val),
		.rd_sel   (rd_sel),
		.src_sel  (src_sel),
		.rd_data  (rd_data),
		.src_byte (src_byte)
	);

endmodule // sm83_regs_top

/* design/regs_read_mux.sv */
// Pair and byte read multiplexer

`timescale 1ns/1ps

module regs_read_mux #(
	parameter int num_pairs = 6
) (
	input  logic [15:0]                     values [num_pairs],
	input  logic [sm83_regs_pkg::wb_aw-1:0] rd_sel,
	input  logic [3:0]                      src_sel,	// Byte index
	output logic [15:0]                     rd_data,
	output logic [7:0]                      src_byte
);

	// Host read, zero when nothing matches
	always_comb begin
		rd_data = '0;
		for (int i = 0; i < num_pairs; i++) begin
			if (rd_sel == i) begin
				rd_data = values[i];
			end
		end
	end

	// Copy source byte
	always_comb begin
		src_byte = '0;
		for (int i = 0; i < num_pairs; i++) begin
			if (src_sel[3:1] == i) begin
				src_byte = src_sel[0] ? values[i][7:0] : values[i][15:8];
			end
		end
	end

endmodule // regs_read_mux

/* design/reg_pair.sv */
// 16-bit register pair

`timescale 1ns/1ps

module reg_pair (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        we_hi,	// Load byte_data into [15:8]
	input  logic        we_lo,	// Load byte_data into [7:0]
	input  logic [7:0]  byte_data,
	input  logic        op_en,
	input  logic [1:0]  pair_op,
	input  logic [15:0] pair_imm,
	output logic [15:0] value
);

	logic [15:0] op_result;
	logic [15:0] offset;

	assign offset = {{8{pair_imm[7]}}, pair_imm[7:0]};	// Sign-extend low byte

	// All arithmetic wraps at 16 bits
	always_comb begin
		unique case (pair_op)
			sm83_regs_pkg::pop_inc:     op_result = value + 16'd1;
			sm83_regs_pkg::pop_dec:     op_result = value - 16'd1;
			sm83_regs_pkg::pop_load:    op_result = pair_imm;
			sm83_regs_pkg::pop_add_off: op_result = value + offset;
			default:                    op_result = value;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			value <= '0;
		end else if (op_en) begin
			value <= op_result;
		end else begin
			if (we_hi) begin
				value[15:8] <= byte_data;
			end
			if (we_lo) begin
				value[7:0] <= byte_data;
			end
		end
	end

	// Decoder must never combine a byte lane write with a pair op
	a_no_mixed_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(op_en && (we_hi || we_lo))
	) else $error("byte write and pair op in one cycle");

endmodule // reg_pair

/* design/regs_cmd_decode.sv */
// Register command decoder

`timescale 1ns/1ps

module regs_cmd_decode #(
	parameter int num_pairs = 6
) (
	input  logic                    cmd_valid,
	input  sm83_regs_pkg::reg_cmd_u cmd,
	input  logic [7:0]              src_byte,	// From the read mux
	output logic [3:0]              src_sel,
	output logic [num_pairs-1:0]    we_hi,
	output logic [num_pairs-1:0]    we_lo,
	output logic [7:0]              byte_data,
	output logic [num_pairs-1:0]    op_en,
	output logic [1:0]              pair_op,
	output logic [15:0]             pair_imm
);

	localparam int num_bytes = 2 * num_pairs;

	logic is_pair;
	logic dst_ok;
	logic src_ok;
	logic idx_ok;
	logic cmd_ok;

	assign is_pair = cmd.p.is_pair;	// Bit 31, same place in both views

	// Range checks per view
	assign dst_ok = cmd.b.dst < num_bytes;
	assign src_ok = cmd.b.use_imm || (cmd.b.src < num_bytes);
	assign idx_ok = cmd.p.idx < num_pairs;
	assign cmd_ok = is_pair ? idx_ok : (dst_ok && src_ok);

	// Byte view operands
	assign src_sel   = cmd.b.src;
	assign byte_data = cmd.b.use_imm ? cmd.b.imm : src_byte;

	// Pair view operands, shared by all pairs
	assign pair_op  = cmd.p.op;
	assign pair_imm = cmd.p.imm;

	always_comb begin
		we_hi = '0;
		we_lo = '0;
		op_en = '0;
		if (cmd_valid && cmd_ok) begin
			if (is_pair) begin
				for (int i = 0; i < num_pairs; i++) begin
					if (cmd.p.idx == i) begin
						op_en[i] = 1'b1;
					end
				end
			end else begin
				// Byte index over two picks the pair, bit 0 the lane
				for (int i = 0; i < num_pairs; i++) begin
					if (cmd.b.dst[3:1] == i) begin
						we_hi[i] = !cmd.b.dst[0];
						we_lo[i] = cmd.b.dst[0];
					end
				end
			end
		end
	end

	// Host software should never name a byte or pair past num_pairs
	always_comb begin
		a_cmd_in_range: assert final (cmd_valid !== 1'b1 || cmd_ok)
			else $error("command index outside %0d pairs: %h", num_pairs, cmd);
	end

endmodule // regs_cmd_decode

/* design/regs_wb_port.sv */
// Wishbone classic slave port

`timescale 1ns/1ps

module regs_wb_port (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             wb_cyc,
	input  logic                             wb_stb,
	input  logic                             wb_we,
	input  logic [sm83_regs_pkg::wb_aw-1:0]  wb_adr,
	input  logic [sm83_regs_pkg::wb_dw-1:0]  wb_dat_w,
	input  logic [15:0]                      rd_data,	// Pair picked by rd_sel
	output logic                             wb_ack,
	output logic [sm83_regs_pkg::wb_dw-1:0]  wb_dat_r,
	output logic                             cmd_valid,
	output sm83_regs_pkg::reg_cmd_u          cmd,
	output logic [sm83_regs_pkg::wb_aw-1:0]  rd_sel
);

	logic req;	// Qualified strobe not yet acknowledged

	assign req = wb_cyc && wb_stb && !wb_ack;

	// Command fires in the cycle whose closing edge raises ack
	assign cmd_valid = req && wb_we && (wb_adr == sm83_regs_pkg::cmd_adr);
	assign cmd       = wb_dat_w;
	assign rd_sel    = wb_adr;	// Mux answers combinationally

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;	// Drops next cycle since req needs ack low
		end
	end

	// Read data captured on the ack edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_dat_r <= '0;
		end else if (req && !wb_we) begin
			wb_dat_r <= {{(sm83_regs_pkg::wb_dw-16){1'b0}}, rd_data};
		end
	end

	// Master may only strobe inside an open bus cycle
	a_stb_needs_cyc: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_stb |-> wb_cyc
	) else $error("wb_stb high without wb_cyc");

endmodule // regs_wb_port

/* design/sm83_regs_pkg.sv */
// SM83 register block definitions

package sm83_regs_pkg;

	// Wishbone slave geometry
	localparam int wb_dw = 32;
	localparam int wb_aw = 3;

	localparam logic [wb_aw-1:0] cmd_adr = 3'd7;	// Command word lands here

	// Pair operations
	localparam logic [1:0] pop_inc     = 2'd0;
	localparam logic [1:0] pop_dec     = 2'd1;
	localparam logic [1:0] pop_load    = 2'd2;
	localparam logic [1:0] pop_add_off = 2'd3;	// Signed 8-bit offset in imm[7:0]

	// Byte command, bit 31 low
	typedef struct packed {
		logic        is_pair;	// Always 0 in this view
		logic [3:0]  dst;	// Byte index, even is high byte
		logic [3:0]  src;	// Byte index for copies
		logic        use_imm;
		logic [13:0] rsvd;
		logic [7:0]  imm;
	} byte_cmd_t;

	// Pair command, bit 31 high
	typedef struct packed {
		logic        is_pair;	// Always 1 in this view
		logic [1:0]  op;
		logic [2:0]  idx;	// BC, DE, HL, SP, PC, WZ
		logic [9:0]  rsvd;
		logic [15:0] imm;
	} pair_cmd_t;

	// One command word, two decodings selected by bit 31
	typedef union packed {
		byte_cmd_t b;
		pair_cmd_t p;
	} reg_cmd_u;

endpackage // sm83_regs_pkg
